//--- include/tempSense_cfg.svh
`ifndef TEMPSENSE_CFG_SVH
`define TEMPSENSE_CFG_SVH

// phase lengths in clock cycles

// capacitor precharge after reset
`define PRECHARGE_CYCLES 17

// small diode charge
`define DIODE_CYCLES 3

// upper bound, a settled loop cuts it short
`define BIG_DIODE_CYCLES 7

// bandgap output phase
`define OUTPUT_CYCLES 17

// calibration

// low comparator samples that end a setup loop
`define SETTLE_LOWS 5

// phase and settle counters
`define COUNT_WIDTH 6

`endif

//--- source/phaseTimer.sv
`default_nettype none

module phaseTimer #(
    parameter tempSensePkg::count_t RESET_COUNT = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  tempSensePkg::count_t loadValue,
    output logic                 lastCycle
);
    import tempSensePkg::*;

    count_t count;

    // counts down to zero and rests there until the next load
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= RESET_COUNT;
        end else if (load) begin
            count <= loadValue;
        end else if (count != '0) begin
            count <= count - count_t'(1);
        end
    end

    assign lastCycle = (count == count_t'(1));

    // a zero length phase would never see its last cycle
    loadNonZero: assert property (
        @(posedge clk) disable iff (reset)
        load |-> (loadValue != '0)
    );

endmodule

`default_nettype wire

//--- source/sensorSequencer.sv
`default_nettype none

`include "tempSense_cfg.svh"

module sensorSequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  lastCycle,
    input  logic                  settled,
    output logic                  load,
    output tempSensePkg::count_t  loadValue,
    output logic                  chop,
    output tempSensePkg::opMode_t mode,
    output tempSensePkg::phase_t  phase
);
    import tempSensePkg::*;

    opMode_t modeNext;
    phase_t  phaseNext;
    phase_t  afterBlank;
    phase_t  afterBlankNext;
    logic    handOver;
    logic    handOverNext;

    always_comb begin
        modeNext       = mode;
        phaseNext      = phase;
        afterBlankNext = afterBlank;
        handOverNext   = handOver;
        load           = 1'b0;
        loadValue      = '0;
        case (phase)
            precharge: begin
                if (lastCycle) begin
                    phaseNext      = blankBig;
                    afterBlankNext = bigDiode;
                end
            end
            blankBig: begin
                phaseNext = afterBlank;
                if (afterBlank == bigDiode) begin
                    load      = 1'b1;
                    loadValue = count_t'(`BIG_DIODE_CYCLES);
                    // bandgap output done, ptat loop starts here
                    if (handOver) begin
                        modeNext     = ptatSetup;
                        handOverNext = 1'b0;
                    end
                end else if (afterBlank == blankDiode) begin
                    afterBlankNext = diode;
                end else if (afterBlank == outputPhase) begin
                    load      = 1'b1;
                    loadValue = count_t'(`OUTPUT_CYCLES);
                end else if (afterBlank == idle) begin
                    modeNext = tempSense;
                end
            end
            bigDiode: begin
                // settling ends the phase early
                if (settled) begin
                    phaseNext      = blankBig;
                    afterBlankNext = (mode == bgSetup) ? outputPhase : idle;
                end else if (lastCycle) begin
                    phaseNext      = blankBig;
                    afterBlankNext = blankDiode;
                end
            end
            blankDiode: begin
                phaseNext = afterBlank;
                if (afterBlank == diode) begin
                    load      = 1'b1;
                    loadValue = count_t'(`DIODE_CYCLES);
                end else begin
                    afterBlankNext = bigDiode;
                end
            end
            diode: begin
                if (lastCycle) begin
                    phaseNext      = blankDiode;
                    afterBlankNext = blankBig;
                end
            end
            outputPhase: begin
                if (lastCycle) begin
                    phaseNext      = blankBig;
                    afterBlankNext = bigDiode;
                    handOverNext   = 1'b1;
                end
            end
            default: begin
                phaseNext = phase;
            end
        endcase
    end

    // comparator inputs swap when precharge or diode ends
    assign chop = lastCycle && ((phase == precharge) || (phase == diode));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode       <= bgSetup;
            phase      <= precharge;
            afterBlank <= bigDiode;
            handOver   <= 1'b0;
        end else begin
            mode       <= modeNext;
            phase      <= phaseNext;
            afterBlank <= afterBlankNext;
            handOver   <= handOverNext;
        end
    end

    idleOnlyInTempSense: assert property (
        @(posedge clk) disable iff (reset)
        (phase == idle) |-> (mode == tempSense)
    );

endmodule

`default_nettype wire

//--- source/switchDriver.sv
`default_nettype none

module switchDriver (
    input  logic                  clk,
    input  logic                  reset,
    input  tempSensePkg::opMode_t mode,
    input  tempSensePkg::phase_t  phase,
    input  logic                  chop,
    output logic                  pi1,
    output logic                  pi2,
    output logic                  pii1,
    output logic                  pii2,
    output logic                  pa,
    output logic                  pb,
    output logic                  pc,
    output logic                  pd,
    output logic                  sBg2Cmp,
    output logic                  sBgCtrl,
    output logic                  sPtatCtrl,
    output logic                  sCap2Cmp,
    output logic                  sRef2Cmp,
    output logic                  sCapRst,
    output logic                  sPtatOut,
    output logic                  sRdisconN,
    output logic                  preChrg,
    output logic                  setupBias,
    output logic                  cmpP1,
    output logic                  cmpP2
);
    import tempSensePkg::*;

    phase_t lastPhase;
    logic   inPrecharge;
    logic   inOutput;
    logic   inTempSense;

    assign inPrecharge = (phase == precharge);
    assign inOutput    = (phase == outputPhase);
    assign inTempSense = (mode == tempSense);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lastPhase <= precharge;
            pi1       <= 1'b0;
            pi2       <= 1'b0;
            pii1      <= 1'b0;
            pii2      <= 1'b0;
            pa        <= 1'b0;
            pb        <= 1'b0;
            pc        <= 1'b0;
            pd        <= 1'b0;
            sBg2Cmp   <= 1'b0;
            sBgCtrl   <= 1'b0;
            sPtatCtrl <= 1'b0;
            sCap2Cmp  <= 1'b0;
            sRef2Cmp  <= 1'b0;
            sCapRst   <= 1'b0;
            sPtatOut  <= 1'b0;
            sRdisconN <= 1'b0;
            preChrg   <= 1'b0;
            setupBias <= 1'b0;
            cmpP1     <= 1'b1;
            cmpP2     <= 1'b0;
        end else begin
            lastPhase <= phase;
            // a blank leads into its phase unless it just left that phase
            pi1       <= (phase == bigDiode) ||
                         ((phase == blankBig) && (lastPhase != bigDiode));
            pi2       <= (phase == bigDiode);
            pii1      <= (phase == diode) ||
                         ((phase == blankDiode) && (lastPhase != diode));
            pii2      <= (phase == diode);
            pa        <= inOutput;
            pb        <= inPrecharge || inOutput;
            pc        <= inPrecharge || inOutput;
            pd        <= inPrecharge || inOutput;
            sBg2Cmp   <= inPrecharge;
            sCapRst   <= inPrecharge;
            preChrg   <= inPrecharge;
            sBgCtrl   <= (mode == bgSetup);
            sRdisconN <= (mode == bgSetup);
            sPtatCtrl <= (mode == ptatSetup) || inTempSense;
            setupBias <= !inTempSense;
            sCap2Cmp  <= inTempSense;
            sRef2Cmp  <= inTempSense;
            sPtatOut  <= inTempSense;
            if (chop) begin
                cmpP1 <= ~cmpP1;
                cmpP2 <= ~cmpP2;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/tempSenseCtrl.sv
`default_nettype none

`include "tempSense_cfg.svh"

module tempSenseCtrl (
    input  logic clk,
    input  logic reset,
    input  logic cmp,
    output logic pi1,
    output logic pi2,
    output logic pii1,
    output logic pii2,
    output logic pa,
    output logic pb,
    output logic pc,
    output logic pd,
    output logic sBg2Cmp,
    output logic sBgCtrl,
    output logic sPtatCtrl,
    output logic sCap2Cmp,
    output logic sRef2Cmp,
    output logic sCapRst,
    output logic sPtatOut,
    output logic sRdisconN,
    output logic preChrg,
    output logic setupBias,
    output logic cmpP1,
    output logic cmpP2,
    output logic src,
    output logic snk
);
    import tempSensePkg::*;

    logic    load;
    count_t  loadValue;
    logic    lastCycle;
    logic    settled;
    logic    chop;
    opMode_t mode;
    phase_t  phase;

    // precharge is already running when reset releases
    phaseTimer #(
        .RESET_COUNT(count_t'(`PRECHARGE_CYCLES))
    ) i_phaseTimer (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .loadValue(loadValue),
        .lastCycle(lastCycle)
    );

    trimSettler i_trimSettler (
        .clk    (clk),
        .reset  (reset),
        .cmp    (cmp),
        .mode   (mode),
        .phase  (phase),
        .src    (src),
        .snk    (snk),
        .settled(settled)
    );

    sensorSequencer i_sensorSequencer (
        .clk      (clk),
        .reset    (reset),
        .lastCycle(lastCycle),
        .settled  (settled),
        .load     (load),
        .loadValue(loadValue),
        .chop     (chop),
        .mode     (mode),
        .phase    (phase)
    );

    switchDriver i_switchDriver (
        .clk      (clk),
        .reset    (reset),
        .mode     (mode),
        .phase    (phase),
        .chop     (chop),
        .pi1      (pi1),
        .pi2      (pi2),
        .pii1     (pii1),
        .pii2     (pii2),
        .pa       (pa),
        .pb       (pb),
        .pc       (pc),
        .pd       (pd),
        .sBg2Cmp  (sBg2Cmp),
        .sBgCtrl  (sBgCtrl),
        .sPtatCtrl(sPtatCtrl),
        .sCap2Cmp (sCap2Cmp),
        .sRef2Cmp (sRef2Cmp),
        .sCapRst  (sCapRst),
        .sPtatOut (sPtatOut),
        .sRdisconN(sRdisconN),
        .preChrg  (preChrg),
        .setupBias(setupBias),
        .cmpP1    (cmpP1),
        .cmpP2    (cmpP2)
    );

endmodule

`default_nettype wire

//--- source/tempSensePkg.sv
`default_nettype none

`include "tempSense_cfg.svh"

package tempSensePkg;

    // operating mode, walked once after reset
    typedef enum logic [2:0] {
        bgSetup,
        ptatSetup,
        tempSense
    } opMode_t;

    // analog switch phase
    // the blank phases keep conducting phases apart
    typedef enum logic [2:0] {
        precharge,
        blankBig,
        bigDiode,
        blankDiode,
        diode,
        outputPhase,
        idle
    } phase_t;

    // phase timer and low sample counter
    typedef logic [`COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

//--- source/trimSettler.sv
`default_nettype none

`include "tempSense_cfg.svh"

module trimSettler (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmp,
    input  tempSensePkg::opMode_t mode,
    input  tempSensePkg::phase_t  phase,
    output logic                  src,
    output logic                  snk,
    output logic                  settled
);
    import tempSensePkg::*;

    count_t  lowCount;
    count_t  baseCount;
    opMode_t lastMode;
    logic    sampling;
    logic    lowSample;
    logic    modeChanged;

    assign sampling  = (phase == bigDiode);
    assign lowSample = sampling && !cmp;

    // first cycle of a new mode starts counting from zero
    assign modeChanged = (mode != lastMode);
    assign baseCount   = modeChanged ? '0 : lowCount;

    assign settled = lowSample && (baseCount == count_t'(`SETTLE_LOWS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lowCount <= '0;
            lastMode <= bgSetup;
        end else begin
            lowCount <= baseCount + count_t'(lowSample);
            lastMode <= mode;
        end
    end

    // one trim strobe per big diode sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src <= 1'b0;
            snk <= 1'b0;
        end else begin
            src <= sampling && cmp;
            snk <= lowSample;
        end
    end

    srcSnkExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(src && snk)
    );

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
source/tempSensePkg.sv
source/phaseTimer.sv
source/trimSettler.sv
source/sensorSequencer.sv
source/switchDriver.sv
source/tempSenseCtrl.sv
verification/tempSenseTb.sv

//--- verification/tempSenseTb.sv
`default_nettype none

`include "tempSense_cfg.svh"

module tempSenseTb;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 3;
    localparam logic [31:0] SEED = 32'hcb083b53;
    // big diode, small diode and the four blanks between them
    localparam int LOOP_CYCLES = `BIG_DIODE_CYCLES + `DIODE_CYCLES + 4;
    localparam int SETTLE_BOUND = `PRECHARGE_CYCLES + `OUTPUT_CYCLES +
                                  2 * `SETTLE_LOWS * LOOP_CYCLES * 8;
    localparam int HOLD_CYCLES = 40;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SETTLE_BOUND + HOLD_CYCLES + 10;

    logic clk;
    logic reset;
    logic cmp;
    logic pi1;
    logic pi2;
    logic pii1;
    logic pii2;
    logic pa;
    logic pb;
    logic pc;
    logic pd;
    logic sBg2Cmp;
    logic sBgCtrl;
    logic sPtatCtrl;
    logic sCap2Cmp;
    logic sRef2Cmp;
    logic sCapRst;
    logic sPtatOut;
    logic sRdisconN;
    logic preChrg;
    logic setupBias;
    logic cmpP1;
    logic cmpP2;
    logic src;
    logic snk;

    logic [20:0] lowAfterReset;
    logic        ptatMode;
    logic        preChrgLast;
    int          bgLows;
    int          ptatLows;
    int          srcCount;
    int          snkCount;
    int          prechargeRuns;
    int          errorCount = 0;

    tempSenseCtrl i_tempSenseCtrl (
        .clk      (clk),
        .reset    (reset),
        .cmp      (cmp),
        .pi1      (pi1),
        .pi2      (pi2),
        .pii1     (pii1),
        .pii2     (pii2),
        .pa       (pa),
        .pb       (pb),
        .pc       (pc),
        .pd       (pd),
        .sBg2Cmp  (sBg2Cmp),
        .sBgCtrl  (sBgCtrl),
        .sPtatCtrl(sPtatCtrl),
        .sCap2Cmp (sCap2Cmp),
        .sRef2Cmp (sRef2Cmp),
        .sCapRst  (sCapRst),
        .sPtatOut (sPtatOut),
        .sRdisconN(sRdisconN),
        .preChrg  (preChrg),
        .setupBias(setupBias),
        .cmpP1    (cmpP1),
        .cmpP2    (cmpP2),
        .src      (src),
        .snk      (snk)
    );

    // every output except cmpP1
    assign lowAfterReset = {pi1, pi2, pii1, pii2, pa, pb, pc, pd, sBg2Cmp, sBgCtrl,
                            sPtatCtrl, sCap2Cmp, sRef2Cmp, sCapRst, sPtatOut, sRdisconN,
                            preChrg, setupBias, cmpP2, src, snk};
    assign ptatMode = sPtatCtrl && setupBias;

    task automatic flagMismatch(input string msg);
        errorCount++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic printSummary();
        $display("errors: %0d, src pulses: %0d, snk pulses: %0d",
                 errorCount, srcCount, snkCount);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // low samples per calibration loop, seen at the trim outputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bgLows        <= 0;
            ptatLows      <= 0;
            srcCount      <= 0;
            snkCount      <= 0;
            preChrgLast   <= 1'b0;
            prechargeRuns <= 0;
        end else begin
            if (snk && sBgCtrl) begin
                bgLows <= bgLows + 1;
            end
            if (snk && ptatMode) begin
                ptatLows <= ptatLows + 1;
            end
            if (src) begin
                srcCount <= srcCount + 1;
            end
            if (snk) begin
                snkCount <= snkCount + 1;
            end
            preChrgLast <= preChrg;
            if (preChrg && !preChrgLast) begin
                prechargeRuns <= prechargeRuns + 1;
            end
        end
    end

    // first cycle after reset releases
    resetOutputs: assert property (@(posedge clk)
        $fell(reset) |-> (lowAfterReset == '0) && cmpP1
    ) else flagMismatch("outputs not at reset values");

    chopComplement: assert property (@(posedge clk) disable iff (reset)
        cmpP1 != cmpP2
    ) else flagMismatch("cmpP1 and cmpP2 not complementary");

    prechargeLength: assert property (@(posedge clk) disable iff (reset)
        $rose(preChrg) |-> preChrg[*`PRECHARGE_CYCLES] ##1 !preChrg
    ) else flagMismatch("precharge length wrong");

    prechargeSwitches: assert property (@(posedge clk) disable iff (reset)
        preChrg |-> !pa && pb && pc && pd && sCapRst && sBg2Cmp
    ) else flagMismatch("switch levels wrong during precharge");

    noOverlap: assert property (@(posedge clk) disable iff (reset)
        !(pi2 && pii2) && !(pi1 && pii1)
    ) else flagMismatch("big and small diode phases overlap");

    bigDiodeBound: assert property (@(posedge clk) disable iff (reset)
        $rose(pi2) |-> ##[1:`BIG_DIODE_CYCLES] !pi2
    ) else flagMismatch("pi2 held too long");

    diodeLength: assert property (@(posedge clk) disable iff (reset)
        $rose(pii2) |-> pii2[*`DIODE_CYCLES] ##1 !pii2
    ) else flagMismatch("pii2 length wrong");

    // strobe lines up with pi2 and reflects the previous comparator level
    trimFollowsCmp: assert property (@(posedge clk) disable iff (reset)
        pi2 |-> (src == $past(cmp)) && (snk == !$past(cmp))
    ) else flagMismatch("trim pulse does not match comparator sample");

    trimOnlyInBigDiode: assert property (@(posedge clk) disable iff (reset)
        !pi2 |-> !src && !snk
    ) else flagMismatch("trim pulse outside big diode phase");

    trimExclusive: assert property (@(posedge clk) disable iff (reset)
        !(src && snk)
    ) else flagMismatch("src and snk high together");

    bgSettleOutput: assert property (@(posedge clk) disable iff (reset)
        (snk && sBgCtrl && (bgLows == `SETTLE_LOWS - 1)) |->
            ##1 !pa ##1 (pa && pb && pc && pd)[*`OUTPUT_CYCLES]
            ##1 (!pa && sBgCtrl && sRdisconN)
            ##1 (!sBgCtrl && !sRdisconN && sPtatCtrl)
    ) else flagMismatch("bandgap settle sequence wrong");

    outputNotEarly: assert property (@(posedge clk) disable iff (reset)
        $rose(pa) |-> (bgLows == `SETTLE_LOWS)
    ) else flagMismatch("output phase before bandgap loop settled");

    ptatSettleSense: assert property (@(posedge clk) disable iff (reset)
        (snk && ptatMode && (ptatLows == `SETTLE_LOWS - 1)) |->
            ##1 (setupBias && !sCap2Cmp && !src && !snk)
            ##1 (sCap2Cmp && sRef2Cmp && sPtatOut && !setupBias)
    ) else flagMismatch("ptat settle sequence wrong");

    senseNotEarly: assert property (@(posedge clk) disable iff (reset)
        $rose(sCap2Cmp) |-> (ptatLows == `SETTLE_LOWS)
    ) else flagMismatch("tempSense before ptat loop settled");

    senseHolds: assert property (@(posedge clk) disable iff (reset)
        sCap2Cmp |=> sCap2Cmp && sRef2Cmp && sPtatOut && sPtatCtrl && !setupBias
    ) else flagMismatch("tempSense outputs did not hold");

    senseQuiet: assert property (@(posedge clk) disable iff (reset)
        sCap2Cmp |-> !src && !snk && !pi2 && !pii2
    ) else flagMismatch("activity after tempSense reached");

    initial begin : stimulus
        logic [31:0] rnd;
        rnd = $urandom(SEED);
        reset = 1'b1;
        cmp   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (!sCap2Cmp) begin
            @(posedge clk);
            rnd = $urandom();
            cmp <= rnd[0];
        end
        // keep sampling while the mode holds
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            rnd = $urandom();
            cmp <= rnd[0];
        end
        assert (prechargeRuns == 1)
            else flagMismatch("precharge did not run exactly once");
        assert ((bgLows == `SETTLE_LOWS) && (ptatLows == `SETTLE_LOWS))
            else flagMismatch("low sample totals wrong");
        printSummary();
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the controller never reached tempSense mode");
        printSummary();
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
